// ==== files.f ====
+incdir+sim
logic/dijkstra_pkg.sv
logic/host_regs.sv
logic/graph_memory.sv
logic/node_state_memory.sv
logic/relax_stage.sv
logic/min_select_stage.sv
logic/sssp_control.sv
logic/dijkstra_top.sv
sim/tb_dijkstra.sv

// ==== logic/dijkstra_pkg.sv ====
package dijkstra_pkg;

	// graph capacity
	localparam int MAX_NODES = 32;
	localparam int EDGES_PER_NODE = 4;
	localparam int SCAN_WIDTH = 4; // nodes per min-scan cycle

	typedef logic [4:0] node_t;
	typedef logic [5:0] weight_t;
	typedef logic [7:0] dist_t;
	typedef logic [10:0] edge_t; // {neighbour, weight}, weight 0 means no edge

	localparam dist_t DIST_INF = 8'd255;

	// edge entry offsets in a bus word
	localparam int EDGE_LO_POS = 0;
	localparam int EDGE_HI_POS = 15;

	// register map
	localparam logic [2:0] ADDR_NODE_COUNT = 3'd0;
	localparam logic [2:0] ADDR_EDGES_01 = 3'd1;
	localparam logic [2:0] ADDR_EDGES_23 = 3'd2;
	localparam logic [2:0] ADDR_START = 3'd3;
	localparam logic [2:0] ADDR_READ_NODE = 3'd4;

	typedef enum logic [2:0]
	{
		IDLE,
		CLEAR,
		RELAX,
		SELECT,
		FINISH
	} ctrl_state_t;

endpackage

// ==== logic/dijkstra_top.sv ====
`timescale 1ns/100ps

module dijkstra_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        chipselect,
	input  logic        write,
	input  logic [2:0]  address,
	input  logic [31:0] writedata,
	output logic [31:0] readdata
);

	// host side
	logic [5:0] node_count;
	dijkstra_pkg::node_t source, load_node, read_node;
	logic start, edge_we_lo, edge_we_hi;
	dijkstra_pkg::edge_t [1:0] edge_pair;
	dijkstra_pkg::edge_t [dijkstra_pkg::EDGES_PER_NODE-1:0] edges;
	logic busy, node_done;
	dijkstra_pkg::dist_t read_dist;
	dijkstra_pkg::node_t read_prev;
	logic read_visited;

	// controller and relax
	logic clear, visit_we, relax_start, relax_done;
	dijkstra_pkg::node_t visit_node, u;
	dijkstra_pkg::dist_t dist_u;
	dijkstra_pkg::node_t relax_node, relax_prev;
	logic relax_we, relax_visited;
	dijkstra_pkg::dist_t relax_dist, relax_dist_new;

	// min scan
	logic scan_start, scan_done, min_found;
	dijkstra_pkg::node_t min_node;
	dijkstra_pkg::dist_t min_dist;
	dijkstra_pkg::node_t [dijkstra_pkg::SCAN_WIDTH-1:0] scan_node;
	dijkstra_pkg::dist_t [dijkstra_pkg::SCAN_WIDTH-1:0] scan_dist;
	logic [dijkstra_pkg::SCAN_WIDTH-1:0] scan_visited;

	host_regs u_host_regs (
		.clk(clk), .rst_n(rst_n), .chipselect(chipselect), .write(write),
		.address(address), .writedata(writedata), .busy(busy), .node_done(node_done),
		.read_dist(read_dist), .read_prev(read_prev), .read_visited(read_visited),
		.node_count(node_count), .source(source), .start(start), .load_node(load_node),
		.edge_we_lo(edge_we_lo), .edge_we_hi(edge_we_hi), .edge_pair(edge_pair),
		.read_node(read_node), .readdata(readdata)
	);

	graph_memory u_graph_memory (
		.clk(clk), .rst_n(rst_n), .edge_we_lo(edge_we_lo), .edge_we_hi(edge_we_hi),
		.load_node(load_node), .edge_pair(edge_pair), .u(u), .edges(edges)
	);

	node_state_memory u_node_state_memory (
		.clk(clk), .rst_n(rst_n), .clear(clear), .source(source),
		.visit_we(visit_we), .visit_node(visit_node),
		.relax_node(relax_node), .relax_we(relax_we), .relax_dist_new(relax_dist_new),
		.relax_prev(relax_prev), .relax_dist(relax_dist), .relax_visited(relax_visited),
		.scan_node(scan_node), .scan_dist(scan_dist), .scan_visited(scan_visited),
		.read_node(read_node), .read_dist(read_dist), .read_prev(read_prev),
		.read_visited(read_visited)
	);

	relax_stage u_relax_stage (
		.clk(clk), .rst_n(rst_n), .relax_start(relax_start), .u(u), .dist_u(dist_u),
		.edges(edges), .relax_node(relax_node), .relax_we(relax_we),
		.relax_dist_new(relax_dist_new), .relax_prev(relax_prev), .relax_done(relax_done),
		.relax_dist(relax_dist), .relax_visited(relax_visited)
	);

	min_select_stage u_min_select_stage (
		.clk(clk), .rst_n(rst_n), .scan_start(scan_start), .node_count(node_count),
		.scan_node(scan_node), .scan_dist(scan_dist), .scan_visited(scan_visited),
		.scan_done(scan_done), .min_found(min_found), .min_node(min_node),
		.min_dist(min_dist)
	);

	sssp_control u_sssp_control (
		.clk(clk), .rst_n(rst_n), .start(start), .source(source), .clear(clear),
		.visit_we(visit_we), .visit_node(visit_node), .relax_start(relax_start),
		.u(u), .dist_u(dist_u), .relax_done(relax_done), .scan_start(scan_start),
		.scan_done(scan_done), .min_found(min_found), .min_node(min_node),
		.min_dist(min_dist), .busy(busy), .node_done(node_done)
	);

endmodule

// ==== logic/graph_memory.sv ====
`timescale 1ns/100ps

module graph_memory (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic                                                 edge_we_lo,
	input  logic                                                 edge_we_hi,
	input  dijkstra_pkg::node_t                                  load_node,
	input  dijkstra_pkg::edge_t [1:0]                            edge_pair,
	input  dijkstra_pkg::node_t                                  u,
	output dijkstra_pkg::edge_t [dijkstra_pkg::EDGES_PER_NODE-1:0] edges
);

	dijkstra_pkg::edge_t [dijkstra_pkg::EDGES_PER_NODE-1:0] mem [dijkstra_pkg::MAX_NODES];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int n = 0; n < dijkstra_pkg::MAX_NODES; n++)
				mem[n] <= '0; // every edge starts absent
		end
		else
		begin
			if (edge_we_lo)
			begin
				mem[load_node][0] <= edge_pair[0];
				mem[load_node][1] <= edge_pair[1];
			end
			if (edge_we_hi)
			begin
				mem[load_node][2] <= edge_pair[0];
				mem[load_node][3] <= edge_pair[1];
			end
		end
	end

	assign edges = mem[u]; // whole node at once

endmodule

// ==== logic/host_regs.sv ====
`timescale 1ns/100ps

module host_regs (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         chipselect,
	input  logic                         write,
	input  logic [2:0]                   address,
	input  logic [31:0]                  writedata,
	input  logic                         busy,
	input  logic                         node_done,
	input  dijkstra_pkg::dist_t          read_dist,
	input  dijkstra_pkg::node_t          read_prev,
	input  logic                         read_visited,
	output logic [5:0]                   node_count,
	output dijkstra_pkg::node_t          source,
	output logic                         start,
	output dijkstra_pkg::node_t          load_node,
	output logic                         edge_we_lo,
	output logic                         edge_we_hi,
	output dijkstra_pkg::edge_t [1:0]    edge_pair,
	output dijkstra_pkg::node_t          read_node,
	output logic [31:0]                  readdata
);

	logic wr;
	logic cfg_wr; // graph and start writes, locked out while a run is busy

	assign wr = chipselect & write;
	assign cfg_wr = wr & ~busy;

	assign edge_we_lo = cfg_wr && (address == dijkstra_pkg::ADDR_EDGES_01);
	assign edge_we_hi = cfg_wr && (address == dijkstra_pkg::ADDR_EDGES_23);
	assign start = cfg_wr && (address == dijkstra_pkg::ADDR_START);

	assign edge_pair[0] = writedata[dijkstra_pkg::EDGE_LO_POS +: $bits(dijkstra_pkg::edge_t)];
	assign edge_pair[1] = writedata[dijkstra_pkg::EDGE_HI_POS +: $bits(dijkstra_pkg::edge_t)];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			node_count <= '0;
			load_node <= '0;
			source <= '0;
			read_node <= '0;
		end
		else
		begin
			if (cfg_wr && (address == dijkstra_pkg::ADDR_NODE_COUNT))
			begin
				node_count <= writedata[5:0];
				load_node <= '0; // restart graph load
			end
			if (edge_we_hi)
				load_node <= load_node + 5'd1; // second half done, next node
			if (start)
				source <= writedata[4:0];
			if (wr && (address == dijkstra_pkg::ADDR_READ_NODE))
				read_node <= writedata[4:0]; // allowed during a run
		end
	end

	// done, visited, predecessor, distance
	assign readdata = {node_done, 14'd0, read_visited, 3'd0, read_prev, read_dist};

endmodule

// ==== logic/min_select_stage.sv ====
`timescale 1ns/100ps

module min_select_stage (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  logic                                              scan_start,
	input  logic [5:0]                                        node_count,
	output dijkstra_pkg::node_t [dijkstra_pkg::SCAN_WIDTH-1:0] scan_node,
	input  dijkstra_pkg::dist_t [dijkstra_pkg::SCAN_WIDTH-1:0] scan_dist,
	input  logic [dijkstra_pkg::SCAN_WIDTH-1:0]               scan_visited,
	output logic                                              scan_done,
	output logic                                              min_found,
	output dijkstra_pkg::node_t                               min_node,
	output dijkstra_pkg::dist_t                               min_dist
);

	logic issuing;
	logic [2:0] grp;
	logic a_valid, a_last; // stage A register state
	dijkstra_pkg::dist_t a_dist, grp_dist;
	dijkstra_pkg::node_t a_node, grp_node;

	always_comb
	begin
		for (int k = 0; k < dijkstra_pkg::SCAN_WIDTH; k++)
			scan_node[k] = dijkstra_pkg::node_t'(grp * dijkstra_pkg::SCAN_WIDTH + k);
	end

	// best of four, strict compare keeps the lowest index on ties
	always_comb
	begin
		grp_dist = dijkstra_pkg::DIST_INF;
		grp_node = scan_node[0];
		for (int k = 0; k < dijkstra_pkg::SCAN_WIDTH; k++)
		begin
			if (({1'b0, scan_node[k]} < node_count) && !scan_visited[k] &&
				(scan_dist[k] < grp_dist))
			begin
				grp_dist = scan_dist[k];
				grp_node = scan_node[k];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			issuing <= 1'b0;
			grp <= '0;
			a_valid <= 1'b0;
			a_last <= 1'b0;
			scan_done <= 1'b0;
			min_dist <= dijkstra_pkg::DIST_INF;
			min_node <= '0;
		end
		else
		begin
			a_valid <= issuing;
			a_last <= issuing && (grp == 3'(dijkstra_pkg::MAX_NODES / dijkstra_pkg::SCAN_WIDTH - 1));
			scan_done <= a_valid && a_last; // last group merged
			if (scan_start)
			begin
				issuing <= 1'b1;
				grp <= '0;
			end
			else if (issuing)
			begin
				grp <= grp + 3'd1;
				if (grp == 3'(dijkstra_pkg::MAX_NODES / dijkstra_pkg::SCAN_WIDTH - 1))
					issuing <= 1'b0;
			end
			if (scan_start)
			begin
				min_dist <= dijkstra_pkg::DIST_INF;
				min_node <= '0;
			end
			else if (a_valid && (a_dist < min_dist)) // stage B merge
			begin
				min_dist <= a_dist;
				min_node <= a_node;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (issuing)
		begin
			a_dist <= grp_dist;
			a_node <= grp_node;
		end
	end

	assign min_found = (min_dist != dijkstra_pkg::DIST_INF);

endmodule

// ==== logic/node_state_memory.sv ====
`timescale 1ns/100ps

module node_state_memory (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  logic                                              clear,
	input  dijkstra_pkg::node_t                               source,
	input  logic                                              visit_we,
	input  dijkstra_pkg::node_t                               visit_node,
	input  dijkstra_pkg::node_t                               relax_node,
	input  logic                                              relax_we,
	input  dijkstra_pkg::dist_t                               relax_dist_new,
	input  dijkstra_pkg::node_t                               relax_prev,
	output dijkstra_pkg::dist_t                               relax_dist,
	output logic                                              relax_visited,
	input  dijkstra_pkg::node_t [dijkstra_pkg::SCAN_WIDTH-1:0] scan_node,
	output dijkstra_pkg::dist_t [dijkstra_pkg::SCAN_WIDTH-1:0] scan_dist,
	output logic [dijkstra_pkg::SCAN_WIDTH-1:0]               scan_visited,
	input  dijkstra_pkg::node_t                               read_node,
	output dijkstra_pkg::dist_t                               read_dist,
	output dijkstra_pkg::node_t                               read_prev,
	output logic                                              read_visited
);

	dijkstra_pkg::dist_t dist_mem [dijkstra_pkg::MAX_NODES];
	dijkstra_pkg::node_t prev_mem [dijkstra_pkg::MAX_NODES];
	logic [dijkstra_pkg::MAX_NODES-1:0] visited;

	// distance and visited flag
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int n = 0; n < dijkstra_pkg::MAX_NODES; n++)
				dist_mem[n] <= dijkstra_pkg::DIST_INF;
			visited <= '0;
		end
		else if (clear)
		begin
			for (int n = 0; n < dijkstra_pkg::MAX_NODES; n++)
				dist_mem[n] <= dijkstra_pkg::DIST_INF;
			dist_mem[source] <= '0; // overrides the loop for the source
			visited <= '0;
		end
		else
		begin
			if (relax_we)
				dist_mem[relax_node] <= relax_dist_new;
			if (visit_we)
				visited[visit_node] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (clear)
		begin
			for (int n = 0; n < dijkstra_pkg::MAX_NODES; n++)
				prev_mem[n] <= '0;
		end
		else if (relax_we)
			prev_mem[relax_node] <= relax_prev;
	end

	assign relax_dist = dist_mem[relax_node];
	assign relax_visited = visited[relax_node];

	always_comb
	begin
		for (int k = 0; k < dijkstra_pkg::SCAN_WIDTH; k++)
		begin
			scan_dist[k] = dist_mem[scan_node[k]];
			scan_visited[k] = visited[scan_node[k]];
		end
	end

	// host readout port
	assign read_dist = dist_mem[read_node];
	assign read_prev = prev_mem[read_node];
	assign read_visited = visited[read_node];

endmodule

// ==== logic/relax_stage.sv ====
`timescale 1ns/100ps

module relax_stage (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic                                                 relax_start,
	input  dijkstra_pkg::node_t                                  u,
	input  dijkstra_pkg::dist_t                                  dist_u,
	input  dijkstra_pkg::edge_t [dijkstra_pkg::EDGES_PER_NODE-1:0] edges,
	output dijkstra_pkg::node_t                                  relax_node,
	output logic                                                 relax_we,
	output dijkstra_pkg::dist_t                                  relax_dist_new,
	output dijkstra_pkg::node_t                                  relax_prev,
	output logic                                                 relax_done,
	input  dijkstra_pkg::dist_t                                  relax_dist,
	input  logic                                                 relax_visited
);

	logic active;
	logic [1:0] edge_idx;
	dijkstra_pkg::edge_t cur_edge;
	dijkstra_pkg::weight_t cur_weight;
	logic [8:0] sum; // one bit of headroom for the saturation test

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			edge_idx <= '0;
		end
		else if (relax_start)
		begin
			active <= 1'b1;
			edge_idx <= '0;
		end
		else if (active)
		begin
			edge_idx <= edge_idx + 2'd1;
			if (edge_idx == 2'(dijkstra_pkg::EDGES_PER_NODE - 1))
				active <= 1'b0;
		end
	end

	assign cur_edge = edges[edge_idx];
	assign cur_weight = cur_edge[5:0];
	assign relax_node = cur_edge[10:6];

	assign sum = {1'b0, dist_u} + {3'd0, cur_weight};

	// unvisited, shorter than now, and still below infinity
	assign relax_we = active && (cur_weight != '0) && !relax_visited &&
		(sum < {1'b0, dijkstra_pkg::DIST_INF}) && (sum < {1'b0, relax_dist});
	assign relax_dist_new = sum[7:0];
	assign relax_prev = u;

	assign relax_done = active && (edge_idx == 2'(dijkstra_pkg::EDGES_PER_NODE - 1));

endmodule

// ==== logic/sssp_control.sv ====
`timescale 1ns/100ps

module sssp_control (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  dijkstra_pkg::node_t source,
	output logic                clear,
	output logic                visit_we,
	output dijkstra_pkg::node_t visit_node,
	output logic                relax_start,
	output dijkstra_pkg::node_t u,
	output dijkstra_pkg::dist_t dist_u,
	input  logic                relax_done,
	output logic                scan_start,
	input  logic                scan_done,
	input  logic                min_found,
	input  dijkstra_pkg::node_t min_node,
	input  dijkstra_pkg::dist_t min_dist,
	output logic                busy,
	output logic                node_done
);

	dijkstra_pkg::ctrl_state_t state;
	logic enter_relax; // first cycle of RELAX

	assign clear = (state == dijkstra_pkg::CLEAR);
	assign busy = (state != dijkstra_pkg::IDLE);

	// u is marked visited as its edges start
	assign visit_we = enter_relax;
	assign relax_start = enter_relax;
	assign visit_node = u;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= dijkstra_pkg::IDLE;
			enter_relax <= 1'b0;
			scan_start <= 1'b0;
			node_done <= 1'b0;
			u <= '0;
			dist_u <= '0;
		end
		else
		begin
			enter_relax <= 1'b0;
			scan_start <= 1'b0;
			unique case (state)
				dijkstra_pkg::IDLE:
					if (start)
					begin
						node_done <= 1'b0;
						state <= dijkstra_pkg::CLEAR;
					end
				dijkstra_pkg::CLEAR:
				begin
					u <= source; // source register is settled by now
					dist_u <= '0;
					enter_relax <= 1'b1;
					state <= dijkstra_pkg::RELAX;
				end
				dijkstra_pkg::RELAX:
					if (relax_done)
					begin
						scan_start <= 1'b1;
						state <= dijkstra_pkg::SELECT;
					end
				dijkstra_pkg::SELECT:
					if (scan_done)
					begin
						if (min_found)
						begin
							u <= min_node;
							dist_u <= min_dist;
							enter_relax <= 1'b1;
							state <= dijkstra_pkg::RELAX;
						end
						else
							state <= dijkstra_pkg::FINISH; // nothing reachable left
					end
				dijkstra_pkg::FINISH:
				begin
					node_done <= 1'b1;
					state <= dijkstra_pkg::IDLE;
				end
				default:
					state <= dijkstra_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dijkstra testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dijkstra \
	-f files.f -o vsim_dijkstra
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/vsim_dijkstra > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
	exit 0
fi
exit 1

// ==== sim/sssp_ref_model.svh ====
	// graph mirror where weight 0 marks an empty edge slot
	int ref_count;
	int ref_nbr [32][4];
	int ref_wt [32][4];
	int ref_dist [32]; // 255 when unreachable

	// random graph over the first count nodes and no edges on higher nodes
	function automatic void ref_random_graph(input int count);
		ref_count = count;
		for (int n = 0; n < 32; n++)
		begin
			for (int e = 0; e < 4; e++)
			begin
				ref_nbr[n][e] = 0;
				ref_wt[n][e] = 0;
				if (n < count)
				begin
					ref_nbr[n][e] = int'($urandom % count);
					if ($urandom % 4 != 0) // about one slot in four empty
						ref_wt[n][e] = 1 + int'($urandom % 63);
				end
			end
		end
	endfunction

	// plain dijkstra that never writes a sum of 255 or more
	function automatic void ref_run(input int src);
		bit seen [32];
		int u;
		int best;
		int s;
		for (int n = 0; n < 32; n++)
		begin
			ref_dist[n] = 255;
			seen[n] = 1'b0;
		end
		ref_dist[src] = 0;
		repeat (32)
		begin
			u = -1;
			best = 255;
			for (int n = 0; n < ref_count; n++)
			begin
				if (!seen[n] && ref_dist[n] < best)
				begin
					best = ref_dist[n];
					u = n;
				end
			end
			if (u < 0)
				break;
			seen[u] = 1'b1;
			for (int e = 0; e < 4; e++)
			begin
				s = ref_dist[u] + ref_wt[u][e];
				if (ref_wt[u][e] != 0 && !seen[ref_nbr[u][e]] && s < 255 &&
					s < ref_dist[ref_nbr[u][e]])
					ref_dist[ref_nbr[u][e]] = s;
			end
		end
	endfunction

	// some edge p->v lies on a shortest path to v
	function automatic bit pred_edge_ok(input int p, input int v);
		bit ok;
		ok = 1'b0;
		if (p < ref_count && ref_dist[p] != 255)
		begin
			for (int e = 0; e < 4; e++)
				if (ref_wt[p][e] != 0 && ref_nbr[p][e] == v &&
					ref_dist[p] + ref_wt[p][e] == ref_dist[v])
					ok = 1'b1;
		end
		return ok;
	endfunction

// ==== sim/tb_dijkstra.sv ====
`timescale 1ns/100ps

module tb_dijkstra;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_RUNS = 4;
	localparam int RUN_CYCLES = 1000; // watchdog budget per run
	localparam int DONE_LIMIT = 900; // cycles allowed from start to done

	logic clk;
	logic rst_n;
	logic chipselect;
	logic write;
	logic [2:0] address;
	logic [31:0] writedata;
	logic [31:0] readdata;

	int mismatch_count;
	int fail_count;

	`include "sssp_ref_model.svh"

	dijkstra_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.chipselect(chipselect),
		.write(write),
		.address(address),
		.writedata(writedata),
		.readdata(readdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic void report_mismatch(input string msg);
		mismatch_count++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endfunction

	// one bus write that the DUT samples on the second edge
	task automatic bus_write(input logic [2:0] addr, input logic [31:0] data);
		@(posedge clk);
		chipselect <= 1'b1;
		write <= 1'b1;
		address <= addr;
		writedata <= data;
		@(posedge clk);
		chipselect <= 1'b0;
		write <= 1'b0;
	endtask

	task automatic read_node_word(input int n, output logic [31:0] word);
		bus_write(dijkstra_pkg::ADDR_READ_NODE, 32'(n));
		@(negedge clk); // readdata settled
		word = readdata;
	endtask

	// two edge entries at bits 10..0 and 25..15 with the neighbour above the weight
	function automatic logic [31:0] pack_edge_pair(input int n, input int e);
		logic [31:0] word;
		word = '0;
		word[10:6] = 5'(ref_nbr[n][e]);
		word[5:0] = 6'(ref_wt[n][e]);
		word[25:21] = 5'(ref_nbr[n][e + 1]);
		word[20:15] = 6'(ref_wt[n][e + 1]);
		return word;
	endfunction

	task automatic load_graph();
		bus_write(dijkstra_pkg::ADDR_NODE_COUNT, 32'(ref_count)); // also rewinds the pointer
		for (int n = 0; n < ref_count; n++)
		begin
			bus_write(dijkstra_pkg::ADDR_EDGES_01, pack_edge_pair(n, 0));
			bus_write(dijkstra_pkg::ADDR_EDGES_23, pack_edge_pair(n, 2));
		end
	endtask

	task automatic start_run(input int src);
		bus_write(dijkstra_pkg::ADDR_START, 32'(src));
		@(negedge clk);
		assert (readdata[31] == 1'b0)
		else report_mismatch($sformatf("done still high after start from node %0d", src));
	endtask

	// graph and start writes that a busy engine must drop
	task automatic write_while_busy();
		bus_write(dijkstra_pkg::ADDR_NODE_COUNT, 32'd3);
		bus_write(dijkstra_pkg::ADDR_EDGES_01, $urandom);
		bus_write(dijkstra_pkg::ADDR_EDGES_23, $urandom);
		bus_write(dijkstra_pkg::ADDR_START, 32'd1);
		@(negedge clk);
		if (readdata[31])
		begin
			fail_count++;
			$display("run finished before the busy-time writes were issued");
		end
	endtask

	task automatic wait_done(output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < DONE_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			if (readdata[31])
				ok = 1'b1;
		end
		if (!ok)
		begin
			fail_count++;
			$display("run did not finish, done stayed low for %0d cycles", DONE_LIMIT);
		end
	endtask

	task automatic check_results(input int src);
		logic [31:0] word;
		int d;
		int p;
		for (int n = 0; n < 32; n++)
		begin
			read_node_word(n, word);
			d = int'(word[7:0]);
			p = int'(word[12:8]);
			assert (d == ref_dist[n])
			else report_mismatch($sformatf("node %0d distance %0d, expected %0d",
				n, d, ref_dist[n]));
			if (ref_dist[n] == 255)
			begin
				assert (word[16] == 1'b0)
				else report_mismatch($sformatf("unreachable node %0d reads visited",
					n));
			end
			else
			begin
				assert (word[16] == 1'b1)
				else report_mismatch($sformatf("reached node %0d not visited", n));
				if (n != src)
				begin
					assert (pred_edge_ok(p, n))
					else report_mismatch($sformatf(
						"node %0d predecessor %0d is not on a shortest path", n, p));
				end
			end
		end
	endtask

	// load the mirrored graph, run from src and compare every node
	task automatic run_graph(input int src, input bit busy_writes);
		bit ok;
		load_graph();
		ref_run(src);
		start_run(src);
		if (busy_writes)
			write_while_busy();
		wait_done(ok);
		if (ok)
			check_results(src);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		chipselect = 1'b0;
		write = 1'b0;
		address = '0;
		writedata = '0;
		mismatch_count = 0;
		fail_count = 0;
		void'($urandom(32'h25b8));

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (readdata[31] == 1'b0)
		else report_mismatch("done high after reset");

		// full random graph from node 0
		ref_random_graph(32);
		run_graph(0, 1'b0);

		// small graph from a nonzero source where upper nodes stay unreachable
		ref_random_graph(10);
		run_graph(3, 1'b0);

		// writes during a run are dropped and a later reload takes effect
		ref_random_graph(32);
		run_graph(5, 1'b1);
		ref_random_graph(24);
		run_graph(2, 1'b0);

		$display("errors: %0d mismatches, %0d other failures",
			mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog
	initial
	begin
		#(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
		$display("timeout: the test runs did not complete within %0d cycles",
			NUM_RUNS * RUN_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
